// ==== filelist.f ====
mac_pkg.sv
credit_fifo.sv
partial_product_stage.sv
mac_accumulator.sv
mac_flow_ctrl.sv
mac_top.sv
tb_clock.sv
mac_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the multiply-accumulate testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module mac_tb \
    -f filelist.f \
    -o Vmac_tb

# The simulator exits non-zero on failure; the log decides the result
./obj_dir/Vmac_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== mac_tb.sv ====
// Multiply-accumulate testbench
`timescale 1ns/100ps
`default_nettype none

module mac_tb;

    localparam int NUM_SAMPLES    = 400;
    localparam int TIMEOUT_CYCLES = NUM_SAMPLES * 30 + 200;
    localparam int FILL_SAMPLES   = mac_pkg::IN_DEPTH + mac_pkg::OUT_DEPTH;
    localparam int CREDIT_CAP     = mac_pkg::IN_DEPTH + mac_pkg::OUT_DEPTH;
    localparam int HELD_GRANTS    = 3;                  // Credits granted after back-pressure

    logic                        clk;
    logic                        rst_async;
    logic                        sample_valid_i;
    logic [mac_pkg::A_WIDTH-1:0] a_i;
    logic [mac_pkg::B_WIDTH-1:0] b_i;
    logic [mac_pkg::P_WIDTH-1:0] init_i;
    logic                        reload_i;
    logic                        sub_i;
    logic                        credit_o;
    logic                        credit_i;
    logic                        result_valid_o;
    mac_pkg::mac_result_t        result_o;

    logic [mac_pkg::P_WIDTH-1:0] model_acc;
    logic [mac_pkg::P_WIDTH-1:0] expected_q [$];
    int                          sent_count;
    int                          credits_returned;
    int                          grants_total;
    int                          results_total;
    int                          cycle_count;

    tb_clock #(.PERIOD_NS(40)) clock_gen_i (.clk_o(clk));

    mac_top mac_top_i (
        .clk            (clk),
        .rst_async      (rst_async),
        .sample_valid_i (sample_valid_i),
        .a_i            (a_i),
        .b_i            (b_i),
        .init_i         (init_i),
        .reload_i       (reload_i),
        .sub_i          (sub_i),
        .credit_o       (credit_o),
        .credit_i       (credit_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    //////////////////////////////
    // Failure reporting
    //////////////////////////////
    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic fail_run(input string what);
        $display("Error at %0t: %s", $time, what);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [mac_pkg::P_WIDTH-1:0] got,
                               input logic [mac_pkg::P_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic int producer_credit();
        return mac_pkg::IN_DEPTH + credits_returned - sent_count;
    endfunction

    //////////////////////////////
    // Stimulus generation
    //////////////////////////////
    // First samples are fixed corner operands, later ones are mostly random
    task automatic pick_operands(input int idx, output logic [mac_pkg::A_WIDTH-1:0] a,
                                 output logic [mac_pkg::B_WIDTH-1:0] b);
        logic [mac_pkg::A_WIDTH-1:0] a_min;
        logic [mac_pkg::A_WIDTH-1:0] a_max;
        logic [mac_pkg::B_WIDTH-1:0] b_min;
        logic [mac_pkg::B_WIDTH-1:0] b_ones;
        int                          pick;
        a_min  = {1'b1, {(mac_pkg::A_WIDTH - 1){1'b0}}};
        a_max  = {1'b0, {(mac_pkg::A_WIDTH - 1){1'b1}}};
        b_min  = {1'b1, {(mac_pkg::B_WIDTH - 1){1'b0}}};
        b_ones = {mac_pkg::B_HI_WIDTH'($urandom()), {mac_pkg::B_LO_WIDTH{1'b1}}};
        pick   = (idx < 4) ? idx : int'($urandom_range(0, 7));
        case (pick)
            0:
            begin
                a = a_min;                               // Largest positive product
                b = b_min;
            end
            1:
            begin
                a = a_max;
                b = b_min;
            end
            2:
            begin
                a = a_min;
                b = b_ones;
            end
            3:
            begin
                a = a_max;
                b = b_ones;
            end
            default:
            begin
                a = mac_pkg::A_WIDTH'($urandom());
                b = mac_pkg::B_WIDTH'({$urandom(), $urandom()});
            end
        endcase
    endtask

    // Drives one sample and advances the reference model
    task automatic send_sample();
        logic        [mac_pkg::A_WIDTH-1:0] a;
        logic        [mac_pkg::B_WIDTH-1:0] b;
        logic        [95:0]                 init_raw;
        logic        [mac_pkg::P_WIDTH-1:0] init;
        logic                               reload;
        logic                               sub;
        logic signed [mac_pkg::P_WIDTH-1:0] prod;
        pick_operands(sent_count, a, b);
        init_raw = {$urandom(), $urandom(), $urandom()};
        init     = init_raw[mac_pkg::P_WIDTH-1:0];
        reload   = (sent_count >= 4) && ($urandom_range(0, 7) == 0);
        sub      = $urandom_range(0, 1) == 1;
        prod     = $signed(a) * $signed(b);               // Exact 60-bit product
        if (reload)
        begin
            model_acc = init;
        end
        else if (sub)
        begin
            model_acc = model_acc - prod;
        end
        else
        begin
            model_acc = model_acc + prod;
        end
        expected_q.push_back(model_acc);
        sample_valid_i <= 1'b1;
        a_i            <= a;
        b_i            <= b;
        init_i         <= init;
        reload_i       <= reload;
        sub_i          <= sub;
        sent_count++;
    endtask

    task automatic run_producer(input int total);
        int gap_left;
        gap_left = 0;
        while (sent_count < total)
        begin
            @(posedge clk);
            if (gap_left > 0)
            begin
                sample_valid_i <= 1'b0;
                gap_left--;
            end
            else if (producer_credit() > 0)
            begin
                send_sample();
                gap_left = $urandom_range(0, 3);
            end
            else
            begin
                sample_valid_i <= 1'b0;                  // Out of credits
            end
        end
        @(posedge clk);
        sample_valid_i <= 1'b0;
    endtask

    // Bursts of grants with pauses, never more outstanding than the DUT counts
    task automatic run_consumer(input int total);
        int burst_left;
        int pause_left;
        burst_left = 0;
        pause_left = 0;
        while (results_total < total)
        begin
            @(posedge clk);
            if (burst_left > 0 && (grants_total - results_total) < CREDIT_CAP)
            begin
                credit_i <= 1'b1;
                grants_total++;
                burst_left--;
            end
            else
            begin
                credit_i <= 1'b0;
                if (burst_left == 0 && pause_left > 0)
                begin
                    pause_left--;
                end
                else if (burst_left == 0)
                begin
                    burst_left = $urandom_range(1, 6);
                    pause_left = $urandom_range(0, 10);
                end
            end
        end
        @(posedge clk);
        credit_i <= 1'b0;
    endtask

    //////////////////////////////
    // Output monitor and timeout
    //////////////////////////////
    always @(negedge clk)
    begin
        if (!rst_async)
        begin
            if (credit_o)
            begin
                credits_returned++;
            end
            if (credits_returned > sent_count)
            begin
                fail_run("credit_o returned more credits than samples were sent");
            end
            if (result_valid_o)
            begin
                if (results_total >= grants_total)
                begin
                    fail_run("result_valid_o asserted without an output credit");
                end
                if (expected_q.size() == 0)
                begin
                    fail_run("result arrived with no sample outstanding");
                end
                check_value("result_o", result_o, expected_q.pop_front());
                results_total++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            fail_run("timeout, the run exceeded its cycle limit");
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial
    begin
        int wait_cycles;
        void'($urandom(32'h61d368ac));
        rst_async        = 1'b1;
        sample_valid_i   = 1'b0;
        a_i              = '0;
        b_i              = '0;
        init_i           = '0;
        reload_i         = 1'b0;
        sub_i            = 1'b0;
        credit_i         = 1'b0;
        model_acc        = '0;
        sent_count       = 0;
        credits_returned = 0;
        grants_total     = 0;
        results_total    = 0;
        cycle_count      = 0;
        repeat (2) @(posedge clk);
        rst_async <= 1'b0;

        // Idle after reset
        repeat (8)
        begin
            @(negedge clk);
            check_value("result_valid_o", result_valid_o, 1'b0);
            check_value("credit_o", credit_o, 1'b0);
        end

        // Back-pressure, fill both FIFOs with no output credit
        run_producer(FILL_SAMPLES);
        repeat (30) @(posedge clk);
        check_value("producer credit", producer_credit(), 0);

        repeat (HELD_GRANTS)
        begin
            @(posedge clk);
            credit_i <= 1'b1;
            grants_total++;
        end
        @(posedge clk);
        credit_i <= 1'b0;
        wait_cycles = 0;
        while (results_total < HELD_GRANTS)
        begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 20)
            begin
                fail_run("granted results did not arrive");
            end
        end
        repeat (20) @(posedge clk);

        // Random traffic on both sides
        fork
            run_producer(NUM_SAMPLES);
            run_consumer(NUM_SAMPLES);
        join
        repeat (5) @(posedge clk);
        check_value("credit_o pulses", credits_returned, sent_count);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Testbench clock source
`timescale 1ns/100ps
`default_nettype none

module tb_clock
#(
    parameter int PERIOD_NS = 40
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;             // 50 percent duty

endmodule

`default_nettype wire

// ==== mac_top.sv ====
// Streaming multiply-accumulate top level
`timescale 1ns/100ps
`default_nettype none

module mac_top
(
    input  logic                        clk,
    input  logic                        rst_async,
    input  logic                        sample_valid_i,
    input  logic [mac_pkg::A_WIDTH-1:0] a_i,
    input  logic [mac_pkg::B_WIDTH-1:0] b_i,
    input  logic [mac_pkg::P_WIDTH-1:0] init_i,
    input  logic                        reload_i,
    input  logic                        sub_i,
    output logic                        credit_o,
    input  logic                        credit_i,
    output logic                        result_valid_o,
    output mac_pkg::mac_result_t        result_o
);

    mac_pkg::mac_sample_t                   sample_in;
    mac_pkg::mac_sample_t                   sample_head;
    logic                                   sample_ready;
    logic                                   issue;
    logic                                   pp_valid;
    logic signed [mac_pkg::PP_LO_WIDTH-1:0] pp_lo;
    logic signed [mac_pkg::PP_HI_WIDTH-1:0] pp_hi;
    logic                                   pp_reload;
    logic                                   pp_sub;
    logic        [mac_pkg::P_WIDTH-1:0]     pp_init;
    logic                                   acc_valid;
    mac_pkg::mac_result_t                   acc;
    logic                                   result_ready;
    logic                                   result_pop;
    logic        [mac_pkg::FREE_WIDTH-1:0]  result_free;

    assign sample_in.a      = a_i;
    assign sample_in.b      = b_i;
    assign sample_in.init   = init_i;
    assign sample_in.reload = reload_i;
    assign sample_in.sub    = sub_i;

    //////////////////////////////
    // Input buffer
    //////////////////////////////
    credit_fifo #(
        .payload_t   (mac_pkg::mac_sample_t),
        .DEPTH       (mac_pkg::IN_DEPTH)
    ) sample_fifo_i (
        .clk         (clk),
        .rst_async   (rst_async),
        .push_i      (sample_valid_i),                    // Producer holds a credit
        .push_data_i (sample_in),
        .pop_i       (issue),
        .pop_data_o  (sample_head),
        .not_empty_o (sample_ready),
        .free_o      ()
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////
    partial_product_stage pp_stage_i (
        .clk        (clk),
        .rst_async  (rst_async),
        .issue_i    (issue),
        .sample_i   (sample_head),
        .pp_valid_o (pp_valid),
        .pp_lo_o    (pp_lo),
        .pp_hi_o    (pp_hi),
        .reload_o   (pp_reload),
        .sub_o      (pp_sub),
        .init_o     (pp_init)
    );

    mac_accumulator accumulator_i (
        .clk         (clk),
        .rst_async   (rst_async),
        .pp_valid_i  (pp_valid),
        .pp_lo_i     (pp_lo),
        .pp_hi_i     (pp_hi),
        .reload_i    (pp_reload),
        .sub_i       (pp_sub),
        .init_i      (pp_init),
        .acc_valid_o (acc_valid),
        .acc_o       (acc)
    );

    //////////////////////////////
    // Output buffer and control
    //////////////////////////////
    credit_fifo #(
        .payload_t   (mac_pkg::mac_result_t),
        .DEPTH       (mac_pkg::OUT_DEPTH),
        .CNT_WIDTH   (mac_pkg::FREE_WIDTH)
    ) result_fifo_i (
        .clk         (clk),
        .rst_async   (rst_async),
        .push_i      (acc_valid),
        .push_data_i (acc),
        .pop_i       (result_pop),
        .pop_data_o  (result_o),                          // Registered head entry
        .not_empty_o (result_ready),
        .free_o      (result_free)
    );

    mac_flow_ctrl flow_ctrl_i (
        .clk            (clk),
        .rst_async      (rst_async),
        .sample_ready_i (sample_ready),
        .result_free_i  (result_free),
        .result_ready_i (result_ready),
        .credit_i       (credit_i),
        .issue_o        (issue),
        .result_pop_o   (result_pop),
        .credit_o       (credit_o),
        .result_valid_o (result_valid_o)
    );

endmodule

`default_nettype wire

// ==== mac_flow_ctrl.sv ====
// Credit flow control
`timescale 1ns/100ps
`default_nettype none

module mac_flow_ctrl
(
    input  logic                           clk,
    input  logic                           rst_async,
    input  logic                           sample_ready_i,
    input  logic [mac_pkg::FREE_WIDTH-1:0] result_free_i,
    input  logic                           result_ready_i,
    input  logic                           credit_i,
    output logic                           issue_o,
    output logic                           result_pop_o,
    output logic                           credit_o,
    output logic                           result_valid_o
);

    logic [mac_pkg::PIPE_LATENCY-1:0]   issue_sr;         // Bit 0 is the previous cycle
    logic [mac_pkg::INFLIGHT_WIDTH-1:0] inflight_q;       // Issued, not yet in result FIFO
    logic [mac_pkg::FREE_WIDTH-1:0]     inflight_ext;
    logic [mac_pkg::CREDIT_WIDTH-1:0]   out_credit_q;
    logic                               credit_add;

    //////////////////////////////
    // Issue side
    //////////////////////////////
    assign inflight_ext = {{(mac_pkg::FREE_WIDTH - mac_pkg::INFLIGHT_WIDTH){1'b0}}, inflight_q};

    // Reserve a result slot for every sample still in the pipe
    assign issue_o  = sample_ready_i && (result_free_i > inflight_ext);
    assign credit_o = issue_sr[0];                        // One cycle after the pop

    //////////////////////////////
    // Result side
    //////////////////////////////
    assign result_pop_o   = result_ready_i && (out_credit_q != '0);
    assign result_valid_o = result_pop_o;                 // Head data is valid this cycle
    assign credit_add     = credit_i && ((out_credit_q != mac_pkg::CREDIT_MAX) || result_pop_o);

    always_ff @(posedge clk or posedge rst_async)
    begin
        if (rst_async)
        begin
            issue_sr     <= '0;
            inflight_q   <= '0;
            out_credit_q <= '0;
        end
        else
        begin
            issue_sr <= {issue_sr[mac_pkg::PIPE_LATENCY-2:0], issue_o};

            // Leaves the count when its result is pushed
            case ({issue_o, issue_sr[mac_pkg::PIPE_LATENCY-1]})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase

            case ({credit_add, result_pop_o})
                2'b10:   out_credit_q <= out_credit_q + 1'b1;
                2'b01:   out_credit_q <= out_credit_q - 1'b1;
                default: out_credit_q <= out_credit_q;    // Grant and spend cancel
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mac_accumulator.sv ====
// Product recombination and accumulator
`timescale 1ns/100ps
`default_nettype none

module mac_accumulator
(
    input  logic                                   clk,
    input  logic                                   rst_async,
    input  logic                                   pp_valid_i,
    input  logic signed [mac_pkg::PP_LO_WIDTH-1:0] pp_lo_i,
    input  logic signed [mac_pkg::PP_HI_WIDTH-1:0] pp_hi_i,
    input  logic                                   reload_i,
    input  logic                                   sub_i,
    input  logic        [mac_pkg::P_WIDTH-1:0]     init_i,
    output logic                                   acc_valid_o,
    output mac_pkg::mac_result_t                   acc_o
);

    logic [mac_pkg::P_WIDTH-1:0] lo_ext;
    logic [mac_pkg::P_WIDTH-1:0] hi_ext;
    logic [mac_pkg::P_WIDTH-1:0] product;
    logic [mac_pkg::P_WIDTH-1:0] acc_q;
    logic [mac_pkg::P_WIDTH-1:0] acc_next;

    //////////////////////////////
    // Recombine partial products
    //////////////////////////////
    assign lo_ext = {{(mac_pkg::P_WIDTH - mac_pkg::PP_LO_WIDTH){pp_lo_i[mac_pkg::PP_LO_WIDTH-1]}},
                     pp_lo_i};

    // High product sits 17 bits up
    assign hi_ext = {{(mac_pkg::P_WIDTH - mac_pkg::PP_HI_WIDTH - mac_pkg::B_LO_WIDTH)
                        {pp_hi_i[mac_pkg::PP_HI_WIDTH-1]}},
                     pp_hi_i,
                     {mac_pkg::B_LO_WIDTH{1'b0}}};

    assign product = lo_ext + hi_ext;                     // Full 60-bit a*b, sign extended

    //////////////////////////////
    // Reload or add/sub
    //////////////////////////////
    always_comb
    begin
        if (reload_i)
        begin
            acc_next = init_i;                            // Product ignored
        end
        else if (sub_i)
        begin
            acc_next = acc_q - product;
        end
        else
        begin
            acc_next = acc_q + product;
        end
    end

    always_ff @(posedge clk or posedge rst_async)
    begin
        if (rst_async)
        begin
            acc_q       <= '0;
            acc_valid_o <= 1'b0;
        end
        else
        begin
            if (pp_valid_i)
            begin
                acc_q <= acc_next;                        // Wraps modulo 2^65
            end
            acc_valid_o <= pp_valid_i;                    // Pushes the result FIFO
        end
    end

    assign acc_o = acc_q;

endmodule

`default_nettype wire

// ==== partial_product_stage.sv ====
// Partial product register stage
`timescale 1ns/100ps
`default_nettype none

module partial_product_stage
(
    input  logic                                   clk,
    input  logic                                   rst_async,
    input  logic                                   issue_i,
    input  mac_pkg::mac_sample_t                   sample_i,
    output logic                                   pp_valid_o,
    output logic signed [mac_pkg::PP_LO_WIDTH-1:0] pp_lo_o,
    output logic signed [mac_pkg::PP_HI_WIDTH-1:0] pp_hi_o,
    output logic                                   reload_o,
    output logic                                   sub_o,
    output logic        [mac_pkg::P_WIDTH-1:0]     init_o
);

    logic signed [mac_pkg::A_WIDTH-1:0]     a_s;
    logic signed [mac_pkg::B_LO_WIDTH:0]    b_lo_s;       // Low slice plus a zero sign bit
    logic signed [mac_pkg::B_HI_WIDTH-1:0]  b_hi_s;
    logic signed [mac_pkg::PP_LO_WIDTH-1:0] lo_full;

    //////////////////////////////
    // Slice b and multiply
    //////////////////////////////
    assign a_s    = $signed(sample_i.a);
    assign b_lo_s = $signed({1'b0, sample_i.b[mac_pkg::B_LO_WIDTH-1:0]});
    assign b_hi_s = $signed(sample_i.b[mac_pkg::B_WIDTH-1:mac_pkg::B_LO_WIDTH]);

    // a times an unsigned 17-bit value always fits in 42 signed bits
    assign lo_full = a_s * b_lo_s;

    // Products and the sample's control fields move together
    always_ff @(posedge clk)
    begin
        if (issue_i)
        begin
            pp_lo_o  <= lo_full;
            pp_hi_o  <= a_s * b_hi_s;                     // Weight 2^17 applied later
            reload_o <= sample_i.reload;
            sub_o    <= sample_i.sub;
            init_o   <= sample_i.init;
        end
    end

    always_ff @(posedge clk or posedge rst_async)
    begin
        if (rst_async)
        begin
            pp_valid_o <= 1'b0;
        end
        else
        begin
            pp_valid_o <= issue_i;                        // One cycle after issue
        end
    end

endmodule

`default_nettype wire

// ==== credit_fifo.sv ====
// Small synchronous FIFO
`timescale 1ns/100ps
`default_nettype none

module credit_fifo
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,
    parameter int  PTR_WIDTH = $clog2(DEPTH),
    parameter int  CNT_WIDTH = $clog2(DEPTH + 1)
)
(
    input  logic                 clk,
    input  logic                 rst_async,
    input  logic                 push_i,
    input  payload_t             push_data_i,
    input  logic                 pop_i,
    output payload_t             pop_data_o,
    output logic                 not_empty_o,
    output logic [CNT_WIDTH-1:0] free_o
);

    payload_t               mem [DEPTH];
    logic   [PTR_WIDTH-1:0] wr_ptr;
    logic   [PTR_WIDTH-1:0] rd_ptr;
    logic   [CNT_WIDTH-1:0] count_q;                      // Entries held

    assign pop_data_o  = mem[rd_ptr];                     // Head visible before pop
    assign not_empty_o = (count_q != '0);
    assign free_o      = CNT_WIDTH'(DEPTH) - count_q;

    //////////////////////////////
    // Storage
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (push_i)
        begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////
    always_ff @(posedge clk or posedge rst_async)
    begin
        if (rst_async)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (push_i)
            begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i)
            begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;              // Idle or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mac_pkg.sv ====
// Multiply-accumulate shared definitions
`default_nettype none

package mac_pkg;

    //////////////////////////////
    // Operand and result widths
    //////////////////////////////
    localparam int A_WIDTH     = 25;                      // Signed multiplicand
    localparam int B_WIDTH     = 35;                      // Signed multiplier
    localparam int B_LO_WIDTH  = 17;                      // Unsigned low slice, also the shift
    localparam int B_HI_WIDTH  = B_WIDTH - B_LO_WIDTH;    // Signed high slice
    localparam int PP_LO_WIDTH = A_WIDTH + B_LO_WIDTH;    // a times low slice
    localparam int PP_HI_WIDTH = A_WIDTH + B_HI_WIDTH;    // a times high slice
    localparam int P_WIDTH     = 65;                      // Accumulator, wraps modulo 2^65

    //////////////////////////////
    // Buffering and flow control
    //////////////////////////////
    localparam int IN_DEPTH       = 4;                    // Sample FIFO, producer start credit
    localparam int OUT_DEPTH      = 4;                    // Result FIFO
    localparam int PIPE_LATENCY   = 2;                    // Issue to result push
    localparam int FREE_WIDTH     = $clog2(OUT_DEPTH + 1);
    localparam int INFLIGHT_WIDTH = $clog2(PIPE_LATENCY + 1);
    localparam int CREDIT_WIDTH   = $clog2(OUT_DEPTH + IN_DEPTH + 1);

    // Ceiling of the output credit counter
    localparam logic [CREDIT_WIDTH-1:0] CREDIT_MAX = CREDIT_WIDTH'(OUT_DEPTH + IN_DEPTH);

    //////////////////////////////
    // Payload types
    //////////////////////////////
    typedef struct packed {
        logic [A_WIDTH-1:0] a;                            // Two's complement
        logic [B_WIDTH-1:0] b;                            // Two's complement
        logic [P_WIDTH-1:0] init;                         // Reload value
        logic               reload;                       // Replace accumulator with init
        logic               sub;                          // 1 subtracts the product
    } mac_sample_t;

    typedef logic [P_WIDTH-1:0] mac_result_t;

endpackage

`default_nettype wire
